//--- dmaPkg.sv
// DMA datapath shared package with register map, opcodes and bus structs
package dmaPkg;

  localparam int numChannels  = 4;
  localparam int addrWidth    = 16;
  localparam int regAddrWidth = 4;

  // CPU register map
  localparam logic [regAddrWidth-1:0] regChanAddr0     = 4'h0;
  localparam logic [regAddrWidth-1:0] regChanCount0    = 4'h1;
  localparam logic [regAddrWidth-1:0] regChanAddr1     = 4'h2;
  localparam logic [regAddrWidth-1:0] regChanCount1    = 4'h3;
  localparam logic [regAddrWidth-1:0] regChanAddr2     = 4'h4;
  localparam logic [regAddrWidth-1:0] regChanCount2    = 4'h5;
  localparam logic [regAddrWidth-1:0] regChanAddr3     = 4'h6;
  localparam logic [regAddrWidth-1:0] regChanCount3    = 4'h7;
  localparam logic [regAddrWidth-1:0] regCommandStatus = 4'h8;
  localparam logic [regAddrWidth-1:0] regRequest       = 4'h9;
  localparam logic [regAddrWidth-1:0] regSingleMask    = 4'hA;
  localparam logic [regAddrWidth-1:0] regMode          = 4'hB;
  localparam logic [regAddrWidth-1:0] regClearFf       = 4'hC;
  localparam logic [regAddrWidth-1:0] regMasterClear   = 4'hD;
  localparam logic [regAddrWidth-1:0] regClearMask     = 4'hE;
  localparam logic [regAddrWidth-1:0] regAllMask       = 4'hF;

  // Bit positions inside the written data byte
  localparam int modeAutoInitBit = 4;
  localparam int modeDecrementBit = 5;
  localparam int cmdDisableBit   = 2;
  localparam int requestSetBit   = 2;

  typedef enum logic [3:0] {
    opNone,
    opWrAddr,
    opWrCount,
    opRdAddr,
    opRdCount,
    opWrCommand,
    opRdStatus,
    opWrRequest,
    opWrSingleMask,
    opWrMode,
    opClearFf,
    opMasterClear,
    opClearMask,
    opWrAllMask
  } dmaOpT;

  typedef struct packed {
    logic                    csN;
    logic                    iorN;
    logic                    iowN;
    logic [regAddrWidth-1:0] addr;
    logic [7:0]              data;
  } cpuBusT;

  typedef struct packed {
    dmaOpT      op;
    logic [1:0] chan;
    logic       highByte;
    logic [7:0] data;
  } regCmdT;

  typedef struct packed {
    logic autoInit;
    logic decrement;
  } chanModeT;

endpackage

//--- dmaCpuPort.sv
// DMA CPU register port that decodes bus accesses and returns read data
`timescale 1ns/1ps

module dmaCpuPort (
  input  logic            dma_if,
  input  logic            rstN,
  input  dmaPkg::cpuBusT  cpuBus,
  input  logic [7:0]      chanRdByte,
  input  logic [7:0]      statusByte,
  output dmaPkg::regCmdT  regCmd,
  output logic [7:0]      rdData
);

  dmaPkg::cpuBusT busQ;
  logic           bytePtr;
  logic           wrAcc;
  logic           rdAcc;

  // Bus sampled once per edge, idle after reset
  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
    begin
      busQ.csN  <= 1'b1;
      busQ.iorN <= 1'b1;
      busQ.iowN <= 1'b1;
      busQ.addr <= '0;
      busQ.data <= '0;
    end
    else
      busQ <= cpuBus;
  end

  assign wrAcc = !busQ.csN && !busQ.iowN;
  assign rdAcc = !busQ.csN && !busQ.iorN;

  always_comb
  begin
    regCmd.op       = dmaPkg::opNone;
    regCmd.chan     = busQ.data[1:0];
    regCmd.highByte = bytePtr;
    regCmd.data     = busQ.data;
    case (busQ.addr)
      dmaPkg::regChanAddr0, dmaPkg::regChanAddr1,
      dmaPkg::regChanAddr2, dmaPkg::regChanAddr3:
      begin
        regCmd.chan = busQ.addr[2:1];
        if (wrAcc)
          regCmd.op = dmaPkg::opWrAddr;
        else if (rdAcc)
          regCmd.op = dmaPkg::opRdAddr;
      end
      dmaPkg::regChanCount0, dmaPkg::regChanCount1,
      dmaPkg::regChanCount2, dmaPkg::regChanCount3:
      begin
        regCmd.chan = busQ.addr[2:1];
        if (wrAcc)
          regCmd.op = dmaPkg::opWrCount;
        else if (rdAcc)
          regCmd.op = dmaPkg::opRdCount;
      end
      dmaPkg::regCommandStatus:
      begin
        if (wrAcc)
          regCmd.op = dmaPkg::opWrCommand;
        else if (rdAcc)
          regCmd.op = dmaPkg::opRdStatus;
      end
      // Remaining registers are write-only
      dmaPkg::regRequest:     regCmd.op = wrAcc ? dmaPkg::opWrRequest : dmaPkg::opNone;
      dmaPkg::regSingleMask:  regCmd.op = wrAcc ? dmaPkg::opWrSingleMask : dmaPkg::opNone;
      dmaPkg::regMode:        regCmd.op = wrAcc ? dmaPkg::opWrMode : dmaPkg::opNone;
      dmaPkg::regClearFf:     regCmd.op = wrAcc ? dmaPkg::opClearFf : dmaPkg::opNone;
      dmaPkg::regMasterClear: regCmd.op = wrAcc ? dmaPkg::opMasterClear : dmaPkg::opNone;
      dmaPkg::regClearMask:   regCmd.op = wrAcc ? dmaPkg::opClearMask : dmaPkg::opNone;
      dmaPkg::regAllMask:     regCmd.op = wrAcc ? dmaPkg::opWrAllMask : dmaPkg::opNone;
      default:                regCmd.op = dmaPkg::opNone;
    endcase
  end

  // Byte pointer flip-flop, low byte first
  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
      bytePtr <= 1'b0;
    else if (regCmd.op inside {dmaPkg::opClearFf, dmaPkg::opMasterClear})
      bytePtr <= 1'b0;
    else if (regCmd.op inside {dmaPkg::opWrAddr, dmaPkg::opWrCount,
                               dmaPkg::opRdAddr, dmaPkg::opRdCount})
      bytePtr <= !bytePtr;
  end

  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
      rdData <= '0;
    else if (regCmd.op inside {dmaPkg::opRdAddr, dmaPkg::opRdCount})
      rdData <= chanRdByte;
    else if (regCmd.op == dmaPkg::opRdStatus)
      rdData <= statusByte;
  end

  // Host must never drive both strobes during a select
  strobeExclusive: assert property (@(posedge dma_if) disable iff (!rstN)
    !cpuBus.csN |-> !(!cpuBus.iorN && !cpuBus.iowN))
    else $error("iorN and iowN both low while selected");

endmodule

//--- dmaChannelRegs.sv
// DMA channel register file with address and count stepping and terminal count
`timescale 1ns/1ps

module dmaChannelRegs (
  input  logic                         dma_if,
  input  logic                         rstN,
  input  dmaPkg::regCmdT               regCmd,
  input  dmaPkg::chanModeT             chanMode [dmaPkg::numChannels],
  input  logic [1:0]                   servedChan,
  input  logic                         serveValid,
  input  logic                         xferStb,
  output logic [7:0]                   chanRdByte,
  output logic [dmaPkg::addrWidth-1:0] memAddr,
  output logic                         memValid,
  output logic [3:0]                   tc,
  output logic [3:0]                   tcHit
);

  localparam int aw = dmaPkg::addrWidth;

  logic [aw-1:0] baseAddr  [dmaPkg::numChannels];
  logic [aw-1:0] baseCount [dmaPkg::numChannels];
  logic [aw-1:0] currAddr  [dmaPkg::numChannels];
  logic [aw-1:0] currCount [dmaPkg::numChannels];
  logic [aw-1:0] stepAddr;
  logic [aw-1:0] rdWord;
  logic          fire;
  logic          lastXfer;

  always_comb
  begin
    fire     = xferStb && serveValid;
    lastXfer = (currCount[servedChan] == '0);
    if (chanMode[servedChan].decrement)
      stepAddr = currAddr[servedChan] - 1'b1;
    else
      stepAddr = currAddr[servedChan] + 1'b1;
  end

  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int ch = 0; ch < dmaPkg::numChannels; ch++)
      begin
        baseAddr[ch]  <= '0;
        baseCount[ch] <= '0;
        currAddr[ch]  <= '0;
        currCount[ch] <= '0;
      end
      memAddr  <= '0;
      memValid <= 1'b0;
      tc       <= '0;
    end
    else if (regCmd.op == dmaPkg::opMasterClear)
    begin
      for (int ch = 0; ch < dmaPkg::numChannels; ch++)
      begin
        baseAddr[ch]  <= '0;
        baseCount[ch] <= '0;
        currAddr[ch]  <= '0;
        currCount[ch] <= '0;
      end
      memAddr  <= '0;
      memValid <= 1'b0;
      tc       <= '0;
    end
    else
    begin
      memValid <= fire;
      tc       <= '0;
      if (fire)
      begin
        // Address goes out before the step
        memAddr <= currAddr[servedChan];
        if (lastXfer)
        begin
          tc[servedChan] <= 1'b1;
        end
        if (lastXfer && chanMode[servedChan].autoInit)
        begin
          currAddr[servedChan]  <= baseAddr[servedChan];
          currCount[servedChan] <= baseCount[servedChan];
        end
        else
        begin
          currAddr[servedChan]  <= stepAddr;
          currCount[servedChan] <= currCount[servedChan] - 1'b1;
        end
      end

      // CPU byte loads go to base and current together
      if (regCmd.op == dmaPkg::opWrAddr)
      begin
        if (regCmd.highByte)
        begin
          baseAddr[regCmd.chan][aw-1:8] <= regCmd.data;
          currAddr[regCmd.chan][aw-1:8] <= regCmd.data;
        end
        else
        begin
          baseAddr[regCmd.chan][7:0] <= regCmd.data;
          currAddr[regCmd.chan][7:0] <= regCmd.data;
        end
      end
      else if (regCmd.op == dmaPkg::opWrCount)
      begin
        if (regCmd.highByte)
        begin
          baseCount[regCmd.chan][aw-1:8] <= regCmd.data;
          currCount[regCmd.chan][aw-1:8] <= regCmd.data;
        end
        else
        begin
          baseCount[regCmd.chan][7:0] <= regCmd.data;
          currCount[regCmd.chan][7:0] <= regCmd.data;
        end
      end
    end
  end

  // Read-back of current address or count, byte picked by the pointer
  always_comb
  begin
    if (regCmd.op == dmaPkg::opRdCount)
      rdWord = currCount[regCmd.chan];
    else
      rdWord = currAddr[regCmd.chan];
    chanRdByte = regCmd.highByte ? rdWord[aw-1:8] : rdWord[7:0];
  end

  assign tcHit = tc;

  tcSingleChannel: assert property (@(posedge dma_if) disable iff (!rstN)
    $onehot0(tc))
    else $error("terminal count on more than one channel");

endmodule

//--- dmaCtrlRegs.sv
// DMA control and status registers with fixed-priority channel selection
`timescale 1ns/1ps

module dmaCtrlRegs (
  input  logic             dma_if,
  input  logic             rstN,
  input  dmaPkg::regCmdT   regCmd,
  input  logic [3:0]       tcHit,
  output dmaPkg::chanModeT chanMode [dmaPkg::numChannels],
  output logic [1:0]       servedChan,
  output logic             serveValid,
  output logic [7:0]       statusByte
);

  logic       cmdDisable;
  logic [3:0] maskReg;
  logic [3:0] requestReg;
  logic [3:0] tcFlags;
  logic       statusRead;
  logic       anyReq;

  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int ch = 0; ch < dmaPkg::numChannels; ch++)
        chanMode[ch] <= '0;
      cmdDisable <= 1'b0;
      maskReg    <= '0;
      requestReg <= '0;
      tcFlags    <= '0;
      statusRead <= 1'b0;
    end
    else
    begin
      statusRead <= (regCmd.op == dmaPkg::opRdStatus);
      // Flags drop one edge after the status byte was captured
      if (statusRead)
        tcFlags <= '0;
      case (regCmd.op)
        dmaPkg::opWrMode:
        begin
          chanMode[regCmd.chan].autoInit  <= regCmd.data[dmaPkg::modeAutoInitBit];
          chanMode[regCmd.chan].decrement <= regCmd.data[dmaPkg::modeDecrementBit];
        end
        dmaPkg::opWrCommand:    cmdDisable <= regCmd.data[dmaPkg::cmdDisableBit];
        dmaPkg::opWrRequest:    requestReg[regCmd.chan] <= regCmd.data[dmaPkg::requestSetBit];
        // Single mask value sits in bit 2
        dmaPkg::opWrSingleMask: maskReg[regCmd.chan] <= regCmd.data[2];
        dmaPkg::opWrAllMask:    maskReg <= regCmd.data[3:0];
        dmaPkg::opClearMask:    maskReg <= '0;
        dmaPkg::opMasterClear:
        begin
          for (int ch = 0; ch < dmaPkg::numChannels; ch++)
            chanMode[ch] <= '0;
          cmdDisable <= 1'b0;
          maskReg    <= '1;
          requestReg <= '0;
          tcFlags    <= '0;
          statusRead <= 1'b0;
        end
        default: ;
      endcase
      // Terminal count side effects win over CPU writes
      for (int ch = 0; ch < dmaPkg::numChannels; ch++)
      begin
        if (tcHit[ch])
        begin
          tcFlags[ch]    <= 1'b1;
          requestReg[ch] <= 1'b0;
          if (!chanMode[ch].autoInit)
            maskReg[ch] <= 1'b1;
        end
      end
    end
  end

  // Lowest numbered unmasked request wins
  always_comb
  begin
    servedChan = '0;
    anyReq     = 1'b0;
    for (int ch = dmaPkg::numChannels - 1; ch >= 0; ch--)
    begin
      if (requestReg[ch] && !maskReg[ch])
      begin
        servedChan = 2'(ch);
        anyReq     = 1'b1;
      end
    end
    serveValid = anyReq && !cmdDisable;
  end

  assign statusByte = {requestReg, tcFlags};

  servedUnmasked: assert property (@(posedge dma_if) disable iff (!rstN)
    serveValid |-> !maskReg[servedChan])
    else $error("served channel is masked");

endmodule

//--- dmaDatapath.sv
// DMA datapath top joining the CPU port, channel registers and control registers
`timescale 1ns/1ps

module dmaDatapath (
  input  logic                         dma_if,
  input  logic                         rstN,
  input  dmaPkg::cpuBusT               cpuBus,
  input  logic                         xferStb,
  output logic [7:0]                   rdData,
  output logic [dmaPkg::addrWidth-1:0] memAddr,
  output logic                         memValid,
  output logic [3:0]                   tc
);

  dmaPkg::regCmdT   regCmd;
  dmaPkg::chanModeT chanMode [dmaPkg::numChannels];
  logic [7:0]       chanRdByte;
  logic [7:0]       statusByte;
  logic [3:0]       tcHit;
  logic [1:0]       servedChan;
  logic             serveValid;

  dmaCpuPort dmaCpuPort_i (
    .dma_if     (dma_if),
    .rstN       (rstN),
    .cpuBus     (cpuBus),
    .chanRdByte (chanRdByte),
    .statusByte (statusByte),
    .regCmd     (regCmd),
    .rdData     (rdData)
  );

  dmaChannelRegs dmaChannelRegs_i (
    .dma_if     (dma_if),
    .rstN       (rstN),
    .regCmd     (regCmd),
    .chanMode   (chanMode),
    .servedChan (servedChan),
    .serveValid (serveValid),
    .xferStb    (xferStb),
    .chanRdByte (chanRdByte),
    .memAddr    (memAddr),
    .memValid   (memValid),
    .tc         (tc),
    .tcHit      (tcHit)
  );

  dmaCtrlRegs dmaCtrlRegs_i (
    .dma_if     (dma_if),
    .rstN       (rstN),
    .regCmd     (regCmd),
    .tcHit      (tcHit),
    .chanMode   (chanMode),
    .servedChan (servedChan),
    .serveValid (serveValid),
    .statusByte (statusByte)
  );

endmodule

//--- dmaDatapathTb.sv
// Table-driven self-checking testbench for the DMA register and address datapath
`timescale 1ns/1ps

module dmaDatapathTb;

  localparam int kindWrite   = 0;
  localparam int kindRead    = 1;
  localparam int kindXfer    = 2;
  localparam int kindNoServe = 3;
  localparam int driveDelay  = 1;
  localparam int xferTimeout = 8;

  logic                         dma_if;
  logic                         rstN;
  dmaPkg::cpuBusT               cpuBus;
  logic                         xferStb;
  logic [7:0]                   rdData;
  logic [dmaPkg::addrWidth-1:0] memAddr;
  logic                         memValid;
  logic [3:0]                   tc;

  // Stimulus table, one column per queue
  string       nameQ  [$];
  int          kindQ  [$];
  logic [3:0]  addrQ  [$];
  logic [7:0]  dataQ  [$];
  logic [15:0] expQ   [$];
  logic [3:0]  expTcQ [$];

  int errCount;
  int checkCount;

  dmaDatapath dmaDatapath_i (
    .dma_if   (dma_if),
    .rstN     (rstN),
    .cpuBus   (cpuBus),
    .xferStb  (xferStb),
    .rdData   (rdData),
    .memAddr  (memAddr),
    .memValid (memValid),
    .tc       (tc)
  );

  initial
  begin
    dma_if = 1'b0;
    forever #50 dma_if = !dma_if;
  end

  task automatic addEntry(input string name, input int kind, input logic [3:0] addr,
                          input logic [7:0] data, input logic [15:0] expVal,
                          input logic [3:0] expTc);
    nameQ.push_back(name);
    kindQ.push_back(kind);
    addrQ.push_back(addr);
    dataQ.push_back(data);
    expQ.push_back(expVal);
    expTcQ.push_back(expTc);
  endtask

  task automatic nextCycle();
    @(posedge dma_if);
    #driveDelay;
  endtask

  // One strobe cycle, then two idle cycles so rdData has settled
  task automatic busAccess(input bit isWrite, input logic [3:0] addr, input logic [7:0] data);
    cpuBus.csN  = 1'b0;
    cpuBus.iowN = !isWrite;
    cpuBus.iorN = isWrite;
    cpuBus.addr = addr;
    cpuBus.data = data;
    nextCycle();
    cpuBus.csN  = 1'b1;
    cpuBus.iorN = 1'b1;
    cpuBus.iowN = 1'b1;
    repeat (2) nextCycle();
  endtask

  task automatic runXfer(input string name, input logic [15:0] expAddr, input logic [3:0] expTc);
    int waitCount;
    xferStb = 1'b1;
    nextCycle();
    xferStb = 1'b0;
    waitCount = 0;
    while (!memValid && waitCount < xferTimeout)
    begin
      nextCycle();
      waitCount++;
    end
    if (!memValid)
    begin
      errCount++;
      $display("Timeout in %s, memValid never went high", name);
    end
    else
    begin
      checkCount += 2;
      if (memAddr !== expAddr)
      begin
        errCount++;
        $display("Fail %s memAddr expected %h actual %h", name, expAddr, memAddr);
      end
      if (tc !== expTc)
      begin
        errCount++;
        $display("Fail %s tc expected %b actual %b", name, expTc, tc);
      end
    end
    // Let the terminal count side effects land
    nextCycle();
  endtask

  task automatic checkNoServe(input string name);
    xferStb = 1'b1;
    nextCycle();
    xferStb = 1'b0;
    repeat (4)
    begin
      checkCount++;
      if (memValid !== 1'b0)
      begin
        errCount++;
        $display("Fail %s memValid expected 0 actual %b", name, memValid);
      end
      nextCycle();
    end
  endtask

  task automatic buildTable();
    logic [15:0] initAddr  [4];
    logic [15:0] initCount [4];
    initAddr  = '{16'h1234, 16'h2000, 16'hABCD, 16'h3000};
    initCount = '{16'd2, 16'd5, 16'd1, 16'd3};
    // Load every channel low byte first, then read the pairs back
    addEntry("clearFf", kindWrite, dmaPkg::regClearFf, 8'h00, 16'h0, 4'h0);
    for (int ch = 0; ch < 4; ch++)
    begin
      addEntry($sformatf("wrAddrLo%0d", ch), kindWrite, 4'(2 * ch), initAddr[ch][7:0], 0, 0);
      addEntry($sformatf("wrAddrHi%0d", ch), kindWrite, 4'(2 * ch), initAddr[ch][15:8], 0, 0);
      addEntry($sformatf("wrCountLo%0d", ch), kindWrite, 4'(2 * ch + 1), initCount[ch][7:0], 0, 0);
      addEntry($sformatf("wrCountHi%0d", ch), kindWrite, 4'(2 * ch + 1), initCount[ch][15:8], 0, 0);
    end
    for (int ch = 0; ch < 4; ch++)
    begin
      addEntry($sformatf("rdAddrLo%0d", ch), kindRead, 4'(2 * ch), 0, initAddr[ch][7:0], 0);
      addEntry($sformatf("rdAddrHi%0d", ch), kindRead, 4'(2 * ch), 0, initAddr[ch][15:8], 0);
      addEntry($sformatf("rdCountLo%0d", ch), kindRead, 4'(2 * ch + 1), 0, initCount[ch][7:0], 0);
      addEntry($sformatf("rdCountHi%0d", ch), kindRead, 4'(2 * ch + 1), 0, initCount[ch][15:8], 0);
    end
    // Channel 0 increments, count 2 ends on the third transfer
    addEntry("modeCh0Inc", kindWrite, dmaPkg::regMode, 8'h00, 0, 0);
    addEntry("reqCh0", kindWrite, dmaPkg::regRequest, 8'h04, 0, 0);
    addEntry("xferCh0First", kindXfer, 0, 0, 16'h1234, 4'b0000);
    addEntry("rdCh0AddrLo", kindRead, dmaPkg::regChanAddr0, 0, 16'h0035, 0);
    addEntry("rdCh0AddrHi", kindRead, dmaPkg::regChanAddr0, 0, 16'h0012, 0);
    addEntry("xferCh0Second", kindXfer, 0, 0, 16'h1235, 4'b0000);
    addEntry("xferCh0Tc", kindXfer, 0, 0, 16'h1236, 4'b0001);
    addEntry("statusTc0", kindRead, dmaPkg::regCommandStatus, 0, 16'h0001, 0);
    addEntry("statusCleared", kindRead, dmaPkg::regCommandStatus, 0, 16'h0000, 0);
    addEntry("xferCh0Done", kindNoServe, 0, 0, 0, 0);
    // Channel 1 decrements
    addEntry("modeCh1Dec", kindWrite, dmaPkg::regMode, 8'h21, 0, 0);
    addEntry("reqCh1", kindWrite, dmaPkg::regRequest, 8'h05, 0, 0);
    addEntry("xferCh1First", kindXfer, 0, 0, 16'h2000, 4'b0000);
    addEntry("rdCh1AddrLo", kindRead, dmaPkg::regChanAddr1, 0, 16'h00FF, 0);
    addEntry("rdCh1AddrHi", kindRead, dmaPkg::regChanAddr1, 0, 16'h001F, 0);
    // Channel 2 with auto-init reloads its base values
    addEntry("unreqCh1", kindWrite, dmaPkg::regRequest, 8'h01, 0, 0);
    addEntry("modeCh2Auto", kindWrite, dmaPkg::regMode, 8'h12, 0, 0);
    addEntry("reqCh2", kindWrite, dmaPkg::regRequest, 8'h06, 0, 0);
    addEntry("xferCh2First", kindXfer, 0, 0, 16'hABCD, 4'b0000);
    addEntry("xferCh2Tc", kindXfer, 0, 0, 16'hABCE, 4'b0100);
    addEntry("reqCh2Again", kindWrite, dmaPkg::regRequest, 8'h06, 0, 0);
    addEntry("xferCh2Reload", kindXfer, 0, 0, 16'hABCD, 4'b0000);
    addEntry("unreqCh2", kindWrite, dmaPkg::regRequest, 8'h02, 0, 0);
    // Priority of channel 1 over 3, then mask and disable
    addEntry("reqCh1Again", kindWrite, dmaPkg::regRequest, 8'h05, 0, 0);
    addEntry("reqCh3", kindWrite, dmaPkg::regRequest, 8'h07, 0, 0);
    addEntry("xferPrioCh1", kindXfer, 0, 0, 16'h1FFF, 4'b0000);
    addEntry("maskCh1", kindWrite, dmaPkg::regSingleMask, 8'h05, 0, 0);
    addEntry("xferPrioCh3", kindXfer, 0, 0, 16'h3000, 4'b0000);
    addEntry("disableAll", kindWrite, dmaPkg::regCommandStatus, 8'h04, 0, 0);
    addEntry("xferDisabled", kindNoServe, 0, 0, 0, 0);
    // Master clear zeroes registers and masks every channel
    addEntry("masterClear", kindWrite, dmaPkg::regMasterClear, 8'h00, 0, 0);
    addEntry("rdMcAddrLo", kindRead, dmaPkg::regChanAddr0, 0, 16'h0000, 0);
    addEntry("rdMcAddrHi", kindRead, dmaPkg::regChanAddr0, 0, 16'h0000, 0);
    addEntry("rdMcCountLo", kindRead, dmaPkg::regChanCount0, 0, 16'h0000, 0);
    addEntry("rdMcCountHi", kindRead, dmaPkg::regChanCount0, 0, 16'h0000, 0);
    addEntry("reqAfterClear", kindWrite, dmaPkg::regRequest, 8'h04, 0, 0);
    addEntry("xferMasked", kindNoServe, 0, 0, 0, 0);
  endtask

  initial
  begin
    rstN        = 1'b0;
    xferStb     = 1'b0;
    cpuBus.csN  = 1'b1;
    cpuBus.iorN = 1'b1;
    cpuBus.iowN = 1'b1;
    cpuBus.addr = '0;
    cpuBus.data = '0;
    errCount    = 0;
    checkCount  = 0;
    buildTable();
    repeat (10) @(posedge dma_if);
    #driveDelay;
    rstN = 1'b1;
    checkCount++;
    if (rdData !== 8'h00 || memValid !== 1'b0 || tc !== 4'h0)
    begin
      errCount++;
      $display("Fail reset expected 0 actual %h %b %b", rdData, memValid, tc);
    end
    for (int i = 0; i < nameQ.size(); i++)
    begin
      case (kindQ[i])
        kindWrite: busAccess(1'b1, addrQ[i], dataQ[i]);
        kindRead:
        begin
          busAccess(1'b0, addrQ[i], dataQ[i]);
          checkCount++;
          if (rdData !== expQ[i][7:0])
          begin
            errCount++;
            $display("Fail %s expected %h actual %h", nameQ[i], expQ[i][7:0], rdData);
          end
        end
        kindXfer: runXfer(nameQ[i], expQ[i], expTcQ[i]);
        default: checkNoServe(nameQ[i]);
      endcase
    end
    $display("Checks %0d, errors %0d", checkCount, errCount);
    if (errCount == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- src.f
dmaPkg.sv
dmaCpuPort.sv
dmaChannelRegs.sv
dmaCtrlRegs.sv
dmaDatapath.sv
dmaDatapathTb.sv
